// ==== build.f ====
+incdir+logic
logic/memPkg.sv
logic/byteRam.sv
logic/memCtrl.sv
logic/instFetch.sv
logic/memSubsystem.sv
tests/tbMemSubsystem.sv

// ==== Makefile ====
TOP := tbMemSubsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 \
		-f build.f \
		--top-module $(TOP) \
		-Mdir obj_dir \
		-o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== tests/tbMemSubsystem.sv ====
`timescale 1ns/1ns

`include "memSettings.svh"

module tbMemSubsystem;

    localparam int RamBytes = 1 << `RAM_ADDR_BITS;
    localparam int Window = 64;
    localparam int AccessTimeout = 400;
    localparam int FetchTimeout = 1500;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              ioBufferFull;
    logic              dcEn;
    memPkg::memOpT     dcOp;
    memPkg::accessLenT dcLen;
    memPkg::addrT      dcAddr;
    memPkg::wordT      dcData;
    logic              dcDone;
    memPkg::wordT      dcResult;
    logic              fetchStall;
    logic              redirectEn;
    memPkg::addrT      redirectPc;
    memPkg::ownerT     owner;
    logic              instValid;
    memPkg::wordT      inst;
    memPkg::addrT      instPc;

    integer seed = 11170;

    // mirror of the RAM contents
    memPkg::byteT model [RamBytes];
    memPkg::addrT expPc;
    logic stallOn;
    logic redirectOn;
    int fetchCount;

    memSubsystem u_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dcEn         (dcEn),
        .dcOp         (dcOp),
        .dcLen        (dcLen),
        .dcAddr       (dcAddr),
        .dcData       (dcData),
        .dcDone       (dcDone),
        .dcResult     (dcResult),
        .fetchStall   (fetchStall),
        .redirectEn   (redirectEn),
        .redirectPc   (redirectPc),
        .owner        (owner),
        .instValid    (instValid),
        .inst         (inst),
        .instPc       (instPc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic endInFailure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkData(input memPkg::wordT actual, input memPkg::wordT expected,
                             input memPkg::addrT addr);
        if (actual !== expected) begin
            $display("Fail at %0t: load from %h returned %h, expected %h",
                     $time, addr, actual, expected);
            endInFailure();
        end
    endtask

    task automatic checkInst(input memPkg::wordT actual, input memPkg::wordT expected,
                             input memPkg::addrT pc);
        if (actual !== expected) begin
            $display("Fail at %0t: instruction at %h is %h, expected %h",
                     $time, pc, actual, expected);
            endInFailure();
        end
    endtask

    task automatic checkPc(input memPkg::addrT actual, input memPkg::addrT expected);
        if (actual !== expected) begin
            $display("Fail at %0t: instPc is %h, expected %h", $time, actual, expected);
            endInFailure();
        end
    endtask

    task automatic checkOwner(input memPkg::ownerT actual, input memPkg::ownerT expected);
        if (actual !== expected) begin
            $display("Fail at %0t: owner is %s, expected %s",
                     $time, actual.name(), expected.name());
            endInFailure();
        end
    endtask

    function automatic int pickBelow(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic memPkg::wordT pickWord();
        memPkg::wordT w;
        w = $random(seed);
        return w;
    endfunction

    function automatic memPkg::accessLenT pickLen();
        case (pickBelow(3))
            0: return memPkg::lenByte;
            1: return memPkg::lenHalf;
            default: return memPkg::lenWord;
        endcase
    endfunction

    // window straddles address 0 and random upper bits must be ignored
    function automatic memPkg::addrT pickAddr(input int offset);
        memPkg::addrT a;
        a = pickWord();
        a[`RAM_ADDR_BITS-1:0] = `RAM_ADDR_BITS'(RamBytes - Window / 2 + offset);
        return a;
    endfunction

    // little-endian and zero-extended
    function automatic memPkg::wordT modelRead(input memPkg::addrT addr, input int len);
        memPkg::wordT w;
        logic [`RAM_ADDR_BITS-1:0] idx;
        w = '0;
        for (int i = 0; i < len; i++) begin
            idx = addr[`RAM_ADDR_BITS-1:0] + `RAM_ADDR_BITS'(i);
            w[8*i +: 8] = model[idx];
        end
        return w;
    endfunction

    function automatic void modelWrite(input memPkg::addrT addr, input int len,
                                       input memPkg::wordT data);
        logic [`RAM_ADDR_BITS-1:0] idx;
        for (int i = 0; i < len; i++) begin
            idx = addr[`RAM_ADDR_BITS-1:0] + `RAM_ADDR_BITS'(i);
            model[idx] = data[8*i +: 8];
        end
    endfunction

    // one data access with the request held until dcDone
    task automatic doAccess(input memPkg::memOpT op, input memPkg::accessLenT len,
                            input memPkg::addrT addr, input memPkg::wordT data,
                            output memPkg::wordT result);
        int waited;
        waited = 0;
        @(posedge clk);
        dcEn <= 1'b1;
        dcOp <= op;
        dcLen <= len;
        dcAddr <= addr;
        dcData <= data;
        @(negedge clk);
        while (!dcDone) begin
            waited++;
            if (waited > AccessTimeout) begin
                $display("data access to %h did not complete within %0d cycles",
                         addr, AccessTimeout);
                endInFailure();
            end
            @(negedge clk);
        end
        result = dcResult;
        @(posedge clk);
        dcEn <= 1'b0;
    endtask

    task automatic runOps(input int count);
        memPkg::memOpT op;
        memPkg::accessLenT len;
        memPkg::addrT addr;
        memPkg::wordT data;
        memPkg::wordT result;
        int gap;
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            op = (pickBelow(2) == 0) ? memPkg::opLoad : memPkg::opStore;
            len = pickLen();
            addr = pickAddr(pickBelow(Window));
            data = pickWord();
            gap = pickBelow(4);
            doAccess(op, len, addr, data, result);
            if (op == memPkg::opStore) begin
                modelWrite(addr, int'(len), data);
            end else begin
                checkData(result, modelRead(addr, int'(len)), addr);
            end
            repeat (gap) @(negedge clk);
        end
    endtask

    // byte loads over the window plus the bytes a long store can reach
    task automatic rereadWindow();
        memPkg::addrT addr;
        memPkg::wordT result;
        for (int off = 0; off < Window + 4; off++) begin
            @(negedge clk);
            addr = pickAddr(off);
            doAccess(memPkg::opLoad, memPkg::lenByte, addr, '0, result);
            checkData(result, modelRead(addr, 1), addr);
        end
    endtask

    task automatic awaitFetches(input int more);
        int target;
        int waited;
        target = fetchCount + more;
        waited = 0;
        while (fetchCount < target) begin
            @(posedge clk);
            waited++;
            if (waited > FetchTimeout) begin
                $display("instruction fetch made no progress for %0d cycles", FetchTimeout);
                endInFailure();
            end
        end
    endtask

    // stall levels, fetch hold-off and redirect pulses
    initial begin : backgroundDrive
        int stallLeft;
        int fetchLeft;
        int kind;
        stallLeft = 0;
        fetchLeft = 0;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchStall = 1'b0;
        redirectEn = 1'b0;
        redirectPc = '0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (fetchLeft > 0) begin
                    fetchLeft--;
                end else begin
                    fetchStall <= (pickBelow(4) == 0);
                    fetchLeft = pickBelow(6);
                end
                if (stallLeft > 0) begin
                    stallLeft--;
                end else if (stallOn && pickBelow(6) == 0) begin
                    // kind 0 drops rdy, 1 fills the I/O buffer, 2 does both
                    kind = pickBelow(3);
                    rdy <= (kind == 1);
                    ioBufferFull <= (kind != 0);
                    stallLeft = pickBelow(6);
                end else begin
                    rdy <= 1'b1;
                    ioBufferFull <= 1'b0;
                end
                if (redirectOn && pickBelow(40) == 0) begin
                    redirectEn <= 1'b1;
                    redirectPc <= pickAddr(4 * pickBelow(Window / 4));
                end else begin
                    redirectEn <= 1'b0;
                end
            end
        end
    end

    initial begin : fetchMonitor
        int quiet;
        logic lastDone;
        quiet = 0;
        lastDone = 1'b0;
        expPc = '0;
        fetchCount = 0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                // controller is idle in the cycle after any completion
                if (lastDone) begin
                    checkOwner(owner, memPkg::ownIdle);
                end
                if (dcDone) begin
                    checkOwner(owner, memPkg::ownData);
                end
                if (instValid && redirectEn) begin
                    $display("instruction at %h delivered in a redirect cycle", instPc);
                    endInFailure();
                end
                if (instValid) begin
                    checkPc(instPc, expPc);
                    checkInst(inst, modelRead(instPc, 4), instPc);
                    expPc = expPc + `ADDR_WIDTH'(`PC_STEP);
                    fetchCount++;
                    quiet = 0;
                end else begin
                    quiet++;
                    if (quiet > FetchTimeout) begin
                        $display("no instruction delivered for %0d cycles", FetchTimeout);
                        endInFailure();
                    end
                end
                // next delivery must come from the target
                if (redirectEn) begin
                    expPc = redirectPc;
                end
                lastDone = dcDone || instValid;
            end
        end
    end

    initial begin : mainSequence
        rst = 1'b1;
        dcEn = 1'b0;
        dcOp = memPkg::opLoad;
        dcLen = memPkg::lenWord;
        dcAddr = '0;
        dcData = '0;
        stallOn = 1'b0;
        redirectOn = 1'b0;
        for (int i = 0; i < RamBytes; i++) begin
            model[i] = '0;
        end

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // nobody owns the RAM right after reset
        @(negedge clk);
        checkOwner(owner, memPkg::ownIdle);

        // plain traffic with fetch running alongside
        runOps(60);

        @(negedge clk);
        redirectOn = 1'b1;
        runOps(60);

        @(negedge clk);
        stallOn = 1'b1;
        runOps(80);
        rereadWindow();

        @(negedge clk);
        stallOn = 1'b0;
        redirectOn = 1'b0;
        awaitFetches(4);

        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== logic/memSubsystem.sv ====
`timescale 1ns/1ns

module memSubsystem (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioBufferFull,

    input  logic              dcEn,
    input  memPkg::memOpT     dcOp,
    input  memPkg::accessLenT dcLen,
    input  memPkg::addrT      dcAddr,
    input  memPkg::wordT      dcData,
    output logic              dcDone,
    output memPkg::wordT      dcResult,

    input  logic              fetchStall,
    input  logic              redirectEn,
    input  memPkg::addrT      redirectPc,

    output memPkg::ownerT     owner,
    output logic              instValid,
    output memPkg::wordT      inst,
    output memPkg::addrT      instPc
);

    // fetch unit to controller
    logic         infEn;
    memPkg::addrT infAddr;
    logic         infDone;
    memPkg::wordT infInst;

    // controller to RAM
    memPkg::addrT memAddr;
    logic         memWrite;
    memPkg::byteT memWdata;
    memPkg::byteT memRdata;

    memCtrl uMemCtrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dcEn         (dcEn),
        .dcOp         (dcOp),
        .dcLen        (dcLen),
        .dcAddr       (dcAddr),
        .dcData       (dcData),
        .dcDone       (dcDone),
        .dcResult     (dcResult),
        .infEn        (infEn),
        .infAddr      (infAddr),
        .infDone      (infDone),
        .infInst      (infInst),
        .memAddr      (memAddr),
        .memWrite     (memWrite),
        .memWdata     (memWdata),
        .memRdata     (memRdata),
        .owner        (owner)
    );

    instFetch uInstFetch (
        .clk        (clk),
        .rst        (rst),
        .fetchStall (fetchStall),
        .redirectEn (redirectEn),
        .redirectPc (redirectPc),
        .infEn      (infEn),
        .infAddr    (infAddr),
        .infDone    (infDone),
        .infInst    (infInst),
        .instValid  (instValid),
        .inst       (inst),
        .instPc     (instPc)
    );

    byteRam uByteRam (
        .clk      (clk),
        .memAddr  (memAddr),
        .memWrite (memWrite),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

endmodule

// ==== logic/instFetch.sv ====
`timescale 1ns/1ns

`include "memSettings.svh"

module instFetch (
    input  logic         clk,
    input  logic         rst,
    input  logic         fetchStall,
    input  logic         redirectEn,
    input  memPkg::addrT redirectPc,

    // to memCtrl
    output logic         infEn,
    output memPkg::addrT infAddr,
    input  logic         infDone,
    input  memPkg::wordT infInst,

    output logic         instValid,
    output memPkg::wordT inst,
    output memPkg::addrT instPc
);

    logic inFlight;
    logic pending;
    memPkg::addrT pc;
    memPkg::addrT targetQ;

    // once raised the request holds until infDone, whatever fetchStall does
    assign infEn = inFlight || !fetchStall;
    assign infAddr = pc;

    // fetch overtaken by a redirect is dropped
    assign instValid = infDone && !pending && !redirectEn;
    assign inst = infInst;
    assign instPc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            inFlight <= 1'b0;
            pending <= 1'b0;
        end else if (infDone) begin
            inFlight <= 1'b0;
            pending <= 1'b0;
            if (redirectEn) begin
                pc <= redirectPc;
            end else if (pending) begin
                pc <= targetQ;
            end else begin
                pc <= pc + `ADDR_WIDTH'(`PC_STEP);
            end
        end else begin
            inFlight <= infEn;
            // infAddr must stay put while a request is out
            if (redirectEn && infEn) begin
                pending <= 1'b1;
            end else if (redirectEn) begin
                pc <= redirectPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirectEn) begin
            targetQ <= redirectPc;
        end
    end

endmodule

// ==== logic/memCtrl.sv ====
`timescale 1ns/1ns

module memCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioBufferFull,

    // data client
    input  logic              dcEn,
    input  memPkg::memOpT     dcOp,
    input  memPkg::accessLenT dcLen,
    input  memPkg::addrT      dcAddr,
    input  memPkg::wordT      dcData,
    output logic              dcDone,
    output memPkg::wordT      dcResult,

    // instruction fetch client
    input  logic              infEn,
    input  memPkg::addrT      infAddr,
    output logic              infDone,
    output memPkg::wordT      infInst,

    // byte RAM
    output memPkg::addrT      memAddr,
    output logic              memWrite,
    output memPkg::byteT      memWdata,
    input  memPkg::byteT      memRdata,

    output memPkg::ownerT     owner
);

    logic stall;
    logic busy;
    logic readDone;
    logic storeDone;
    logic [2:0] stage;
    logic [2:0] byteIdx;
    logic [2:0] lastIdx;
    logic [2:0] padBytes;

    memPkg::memOpT     opQ;
    memPkg::accessLenT lenQ;
    memPkg::addrT      baseQ;
    memPkg::wordT      storeQ;
    memPkg::wordT      shiftQ;
    memPkg::wordT      shiftIn;
    memPkg::wordT      assembled;

    // either stall level freezes the sequencer
    assign stall = !rdy || ioBufferFull;
    assign busy = owner != memPkg::ownIdle;

    assign lastIdx = lenQ - 3'd1;
    assign padBytes = 3'd4 - lenQ;

    // stalled mid-read: re-read the previous byte so memRdata still holds it
    // when the transfer resumes
    assign byteIdx = (stall && stage != 3'd0) ? stage - 3'd1 : stage;
    assign memAddr = baseQ + memPkg::addrT'(byteIdx);

    // store bytes go out least significant first
    assign memWdata = memPkg::byteT'(storeQ >> {stage, 3'b000});
    assign memWrite = busy && !stall && opQ == memPkg::opStore && stage <= lastIdx;

    // store finishes with its last byte, reads one cycle after it
    assign storeDone = busy && !stall && opQ == memPkg::opStore && stage == lastIdx;
    assign readDone = busy && !stall && opQ == memPkg::opLoad && stage == lenQ;

    assign dcDone = owner == memPkg::ownData && (readDone || storeDone);
    assign infDone = owner == memPkg::ownFetch && readDone;

    // new byte enters at the top
    assign shiftIn = {memRdata, shiftQ[31:8]};

    // right-align short loads, zeros fill the upper bytes
    assign assembled = shiftIn >> {padBytes, 3'b000};

    assign dcResult = assembled;
    assign infInst = assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= memPkg::ownIdle;
            stage <= 3'd0;
        end else if (!stall) begin
            if (!busy) begin
                stage <= 3'd0;
                // data client wins a tie
                if (dcEn) begin
                    owner <= memPkg::ownData;
                end else if (infEn) begin
                    owner <= memPkg::ownFetch;
                end
            end else if (readDone || storeDone) begin
                owner <= memPkg::ownIdle;
                stage <= 3'd0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    // request latch and read assembly
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (!busy) begin
                if (dcEn) begin
                    opQ <= dcOp;
                    lenQ <= dcLen;
                    baseQ <= dcAddr;
                    storeQ <= dcData;
                end else begin
                    opQ <= memPkg::opLoad;
                    lenQ <= memPkg::lenWord;
                    baseQ <= infAddr;
                end
            end else if (opQ == memPkg::opLoad && stage != 3'd0) begin
                shiftQ <= shiftIn;
            end
        end
    end

endmodule

// ==== logic/byteRam.sv ====
`timescale 1ns/1ns

`include "memSettings.svh"

module byteRam (
    input  logic         clk,
    input  memPkg::addrT memAddr,
    input  logic         memWrite,
    input  memPkg::byteT memWdata,
    output memPkg::byteT memRdata
);

    localparam int Depth = 1 << `RAM_ADDR_BITS;

    memPkg::byteT mem [Depth] = '{default: '0};
    logic [`RAM_ADDR_BITS-1:0] idx;

    // high address bits dropped, accesses wrap
    assign idx = memAddr[`RAM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[idx] <= memWdata;
        end
    end

    // read returns old contents on a same-address write
    always_ff @(posedge clk) begin
        memRdata <= mem[idx];
    end

endmodule

// ==== logic/memPkg.sv ====
`include "memSettings.svh"

package memPkg;

    typedef logic [`ADDR_WIDTH-1:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [7:0] byteT;

    // access length in bytes
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accessLenT;

    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } memOpT;

    // client currently holding the RAM
    typedef enum logic [1:0] {
        ownIdle  = 2'd0,
        ownData  = 2'd1,
        ownFetch = 2'd2
    } ownerT;

endpackage

// ==== logic/memSettings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// byte address width seen by both clients
`define ADDR_WIDTH 32

// low address bits that select a RAM byte
// upper bits are ignored so addresses wrap
`define RAM_ADDR_BITS 12

// fetch PC increment in bytes
`define PC_STEP 4

`endif
